//--- alu_core.sv
/*
 * Combinational Z80 ALU for the eight op543 operations
 * Gives the 8-bit result and the new F value to the execution block
 */
`default_nettype none

module alu_core (
    input  alu_pkg::alu_op_t op,
    input  logic [7:0]       a,
    input  logic [7:0]       b,
    input  logic             carry_in,
    output logic [7:0]       result,
    output logic [7:0]       flags
);
    import alu_pkg::*;

    logic       is_sub;
    logic       is_logic;
    logic       cin;
    logic [8:0] sum;
    logic [4:0] half;
    logic       ovf;
    logic [7:0] res;

    always_comb begin
        // CP runs through the subtract path
        is_sub   = (op == op_sub) || (op == op_sbc) || (op == op_cp);
        is_logic = (op == op_and) || (op == op_xor) || (op == op_or);
        // Only ADC and SBC see the old carry
        cin      = ((op == op_adc) || (op == op_sbc)) ? carry_in : 1'b0;

        // ~~~~~~~~~~~~~~~~~~~~
        // Adder with nibble carry
        // ~~~~~~~~~~~~~~~~~~~~
        if (is_sub) begin
            // Bit 8 is the borrow out
            sum  = {1'b0, a} - {1'b0, b} - 9'(cin);
            half = {1'b0, a[3:0]} - {1'b0, b[3:0]} - 5'(cin);
            // Operands of unlike sign and result sign flipped
            ovf  = (a[7] != b[7]) && (sum[7] != a[7]);
        end else begin
            sum  = {1'b0, a} + {1'b0, b} + 9'(cin);
            half = {1'b0, a[3:0]} + {1'b0, b[3:0]} + 5'(cin);
            // Operands of like sign and result sign flipped
            ovf  = (a[7] == b[7]) && (sum[7] != a[7]);
        end

        // Result select
        case (op)
            op_and:  res = a & b;
            op_xor:  res = a ^ b;
            op_or:   res = a | b;
            default: res = sum[7:0];
        endcase

        // ~~~~~~~~~~~~~~~~~~~~
        // Flag rules
        // ~~~~~~~~~~~~~~~~~~~~
        // Undocumented bits 3 and 5 stay zero
        flags         = 8'h00;
        flags[flag_s] = res[7];
        flags[flag_z] = (res == 8'h00);
        if (is_logic) begin
            // H set by AND only
            flags[flag_h]  = (op == op_and);
            // P/V is even parity here
            flags[flag_pv] = ~^res;
            flags[flag_c]  = 1'b0;
        end else begin
            flags[flag_h]  = half[4];
            flags[flag_pv] = ovf;
            flags[flag_c]  = sum[8];
        end
        flags[flag_n] = is_sub;

        // CP result goes nowhere, the caller skips writeback
        result = res;
    end

endmodule

`default_nettype wire

//--- alu_exec.sv
/*
 * Two-cycle execution control around the ALU
 * Latches operands on start, holds F, writes back result and flags
 */
`default_nettype none

module alu_exec #(
    parameter int  num_regs = 8,
    localparam int idx_w    = $clog2(num_regs)
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             start,
    input  alu_pkg::alu_op_t op,
    input  logic [idx_w-1:0] a_idx,
    input  logic [idx_w-1:0] b_idx,
    input  logic [7:0]       flags_wdata,
    input  logic             flags_we,
    input  logic [7:0]       a_data,
    input  logic [7:0]       b_data,
    output logic [idx_w-1:0] a_sel,
    output logic [idx_w-1:0] b_sel,
    output logic [7:0]       exec_wdata,
    output logic             exec_we,
    output logic             busy,
    output logic [7:0]       flags
);
    import alu_pkg::*;

    // Writable F bits, 3 and 5 masked off
    localparam logic [7:0] flag_mask = 8'((1 << flag_s) | (1 << flag_z) | (1 << flag_h)
        | (1 << flag_pv) | (1 << flag_n) | (1 << flag_c));

    logic [1:0]       cnt;
    alu_op_t          op_q;
    logic [idx_w-1:0] a_idx_q;
    logic [idx_w-1:0] b_idx_q;
    logic [7:0]       a_q;
    logic [7:0]       b_q;
    logic [7:0]       res_q;
    logic [7:0]       new_flags_q;
    logic [7:0]       core_result;
    logic [7:0]       core_flags;

    // Live indices on the start cycle, latched ones while busy
    assign a_sel      = busy ? a_idx_q : a_idx;
    assign b_sel      = busy ? b_idx_q : b_idx;
    assign busy       = (cnt != 2'd0);
    assign exec_wdata = res_q;
    // Second busy cycle writes back, CP only touches F
    assign exec_we    = (cnt == 2'd2) && (op_q != op_cp);

    alu_core u_core (
        .op       (op_q),
        .a        (a_q),
        .b        (b_q),
        .carry_in (flags[flag_c]),
        .result   (core_result),
        .flags    (core_flags)
    );

    // Busy counter and F
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt   <= 2'd0;
            flags <= 8'h00;
        end else begin
            case (cnt)
                2'd0:    cnt <= start ? 2'd1 : 2'd0;
                2'd1:    cnt <= 2'd2;
                default: cnt <= 2'd0;
            endcase
            if (cnt == 2'd2) begin
                flags <= new_flags_q;
            end else if (flags_we) begin
                flags <= flags_wdata & flag_mask;
            end
        end
    end

    // Operand capture, then result register
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            op_q    <= op;
            a_idx_q <= a_idx;
            b_idx_q <= b_idx;
            a_q     <= a_data;
            b_q     <= b_data;
        end
        if (cnt == 2'd1) begin
            res_q       <= core_result;
            new_flags_q <= core_flags;
        end
    end

    // The host port must hold off commands and F writes while busy
    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> !busy)
        else $error("Start while busy");
    a_no_fwe_busy: assert property (@(posedge clk) disable iff (!arst_n)
        flags_we |-> !busy)
        else $error("F write while busy");

endmodule

`default_nettype wire

//--- alu_pkg.sv
/*
 * Shared definitions for the 8-bit ALU unit
 * Op encoding, F bit positions, host address map and command word layout
 */
`default_nettype none

package alu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // ALU operations
    // ~~~~~~~~~~~~~~~~~~~~
    // Same order as the op543 field of the Z80 ALU opcodes
    typedef enum logic [2:0] {
        op_add, op_adc, op_sub, op_sbc, op_and, op_xor, op_or, op_cp
    } alu_op_t;

    // Bit positions inside F, bits 3 and 5 always read zero
    localparam int flag_s  = 7;
    localparam int flag_z  = 6;
    localparam int flag_h  = 4;
    localparam int flag_pv = 2;
    localparam int flag_n  = 1;
    localparam int flag_c  = 0;

    // ~~~~~~~~~~~~~~~~~~~~
    // Host address map
    // ~~~~~~~~~~~~~~~~~~~~
    // Byte addresses, register i sits at addr_reg_base + 4*i
    localparam logic [7:0] addr_cmd      = 8'h00;
    localparam logic [7:0] addr_status   = 8'h04;
    localparam logic [7:0] addr_flags    = 8'h08;
    localparam logic [7:0] addr_reg_base = 8'h40;

    // Command word fields, lsb positions
    localparam int cmd_op_lsb = 0;
    localparam int cmd_a_lsb  = 4;
    localparam int cmd_b_lsb  = 8;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

//--- alu_regs.sv
/*
 * AXI4-Lite slave with command, status, flag and register window
 * Steers the execution block and the register bank
 */
`default_nettype none

module alu_regs #(
    parameter int  num_regs = 8,
    localparam int idx_w    = $clog2(num_regs)
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [7:0]       axi_awaddr,
    input  logic             axi_awvalid,
    output logic             axi_awready,
    input  logic [31:0]      axi_wdata,
    input  logic             axi_wvalid,
    output logic             axi_wready,
    output logic [1:0]       axi_bresp,
    output logic             axi_bvalid,
    input  logic             axi_bready,
    input  logic [7:0]       axi_araddr,
    input  logic             axi_arvalid,
    output logic             axi_arready,
    output logic [31:0]      axi_rdata,
    output logic [1:0]       axi_rresp,
    output logic             axi_rvalid,
    input  logic             axi_rready,
    output logic             start,
    output alu_pkg::alu_op_t op,
    output logic [idx_w-1:0] a_idx,
    output logic [idx_w-1:0] b_idx,
    output logic [7:0]       flags_wdata,
    output logic             flags_we,
    output logic [idx_w-1:0] host_addr,
    output logic [7:0]       host_wdata,
    output logic             host_we,
    input  logic             busy,
    input  logic [7:0]       flags,
    input  logic [7:0]       host_rdata
);
    import alu_pkg::*;

    logic [31:0] cmd_q;
    logic        aw_set;
    logic        wr_fire;
    logic        rd_fire;
    logic        wr_busy;
    logic        wr_hits;

    // Register window hit, word aligned
    function automatic logic in_window(input logic [7:0] addr);
        return (addr >= addr_reg_base) && (addr < addr_reg_base + 8'(4 * num_regs))
            && (addr[1:0] == 2'b00);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Decode
    // ~~~~~~~~~~~~~~~~~~~~
    // Ready pulse when address and data are both up and no response waits
    assign aw_set     = axi_awvalid && axi_wvalid && !axi_bvalid && !axi_awready;
    assign axi_wready = axi_awready;
    assign wr_fire    = axi_awready && axi_awvalid && axi_wvalid;
    assign rd_fire    = axi_arvalid && axi_arready;
    // A pending start counts as busy
    assign wr_busy    = busy || start;
    assign wr_hits    = (axi_awaddr == addr_cmd) || (axi_awaddr == addr_flags)
        || in_window(axi_awaddr);

    assign flags_we    = wr_fire && !wr_busy && (axi_awaddr == addr_flags);
    assign flags_wdata = axi_wdata[7:0];
    assign host_we     = wr_fire && !wr_busy && in_window(axi_awaddr);
    assign host_wdata  = axi_wdata[7:0];
    // Write and read handshakes never share a cycle
    assign host_addr   = axi_awready ? axi_awaddr[2 +: idx_w] : axi_araddr[2 +: idx_w];

    // Command fields to the execution block
    assign op    = alu_op_t'(cmd_q[cmd_op_lsb +: 3]);
    assign a_idx = cmd_q[cmd_a_lsb +: idx_w];
    assign b_idx = cmd_q[cmd_b_lsb +: idx_w];

    // Reads never fail
    assign axi_rresp = resp_okay;

    // ~~~~~~~~~~~~~~~~~~~~
    // Write channel
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            axi_awready <= 1'b0;
            axi_bvalid  <= 1'b0;
            axi_bresp   <= resp_okay;
            cmd_q       <= 32'h0;
            start       <= 1'b0;
        end else begin
            axi_awready <= aw_set;
            start       <= 1'b0;
            if (wr_fire) begin
                axi_bvalid <= 1'b1;
                axi_bresp  <= (wr_busy && wr_hits) ? resp_slverr : resp_okay;
                // Command accepted, start follows one cycle later
                if (!wr_busy && (axi_awaddr == addr_cmd)) begin
                    cmd_q <= axi_wdata;
                    start <= 1'b1;
                end
            end else if (axi_bready) begin
                axi_bvalid <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Read channel
    // ~~~~~~~~~~~~~~~~~~~~
    // arready drops while data waits and in a write handshake cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            axi_arready <= 1'b0;
            axi_rvalid  <= 1'b0;
        end else begin
            axi_arready <= !aw_set && !(rd_fire || (axi_rvalid && !axi_rready));
            if (rd_fire) begin
                axi_rvalid <= 1'b1;
            end else if (axi_rready) begin
                axi_rvalid <= 1'b0;
            end
        end
    end

    // Read data, unmapped reads return zero
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            if (in_window(axi_araddr)) begin
                axi_rdata <= {24'h0, host_rdata};
            end else begin
                case (axi_araddr)
                    addr_cmd:    axi_rdata <= cmd_q;
                    addr_status: axi_rdata <= {16'h0, flags, 7'h0, wr_busy};
                    addr_flags:  axi_rdata <= {24'h0, flags};
                    default:     axi_rdata <= 32'h0;
                endcase
            end
        end
    end

    // Responses hold until the host takes them
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        axi_bvalid && !axi_bready |=> axi_bvalid && $stable(axi_bresp))
        else $error("Write response dropped before bready");
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        axi_rvalid && !axi_rready |=> axi_rvalid && $stable(axi_rdata))
        else $error("Read data dropped before rready");

endmodule

`default_nettype wire

//--- alu_unit_top.sv
/*
 * Top level of the 8-bit ALU unit behind an AXI4-Lite slave
 */
`default_nettype none

module alu_unit_top #(
    parameter int  num_regs = 8,
    localparam int idx_w    = $clog2(num_regs)
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [7:0]  axi_awaddr,
    input  logic        axi_awvalid,
    output logic        axi_awready,
    input  logic [31:0] axi_wdata,
    input  logic        axi_wvalid,
    output logic        axi_wready,
    output logic [1:0]  axi_bresp,
    output logic        axi_bvalid,
    input  logic        axi_bready,
    input  logic [7:0]  axi_araddr,
    input  logic        axi_arvalid,
    output logic        axi_arready,
    output logic [31:0] axi_rdata,
    output logic [1:0]  axi_rresp,
    output logic        axi_rvalid,
    input  logic        axi_rready
);

    // Host port to execution control
    logic             start;
    alu_pkg::alu_op_t op;
    logic [idx_w-1:0] a_idx;
    logic [idx_w-1:0] b_idx;
    logic [7:0]       flags_wdata;
    logic             flags_we;
    logic             busy;
    logic [7:0]       flags;
    // Register bank ports
    logic [idx_w-1:0] host_addr;
    logic [7:0]       host_wdata;
    logic             host_we;
    logic [7:0]       host_rdata;
    logic [idx_w-1:0] a_sel;
    logic [idx_w-1:0] b_sel;
    logic [7:0]       a_data;
    logic [7:0]       b_data;
    logic [7:0]       exec_wdata;
    logic             exec_we;

    alu_regs #(.num_regs(num_regs)) u_regs (.*);
    reg_file #(.num_regs(num_regs)) u_reg_file (.*);
    alu_exec #(.num_regs(num_regs)) u_exec (.*);

endmodule

`default_nettype wire

//--- reg_file.sv
/*
 * Bank of 8-bit general registers
 * Two operand read ports, a host read port, execution and host write ports
 */
`default_nettype none

module reg_file #(
    parameter int  num_regs = 8,
    localparam int idx_w    = $clog2(num_regs)
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [idx_w-1:0] a_sel,
    input  logic [idx_w-1:0] b_sel,
    input  logic [idx_w-1:0] host_addr,
    input  logic [7:0]       exec_wdata,
    input  logic [7:0]       host_wdata,
    input  logic             exec_we,
    input  logic             host_we,
    output logic [7:0]       a_data,
    output logic [7:0]       b_data,
    output logic [7:0]       host_rdata
);

    logic [7:0] regs [num_regs];

    // Asynchronous read ports
    assign a_data     = regs[a_sel];
    assign b_data     = regs[b_sel];
    assign host_rdata = regs[host_addr];

    // Execution result lands in the first operand register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (exec_we) begin
            regs[a_sel] <= exec_wdata;
        end else if (host_we) begin
            regs[host_addr] <= host_wdata;
        end
    end

    // Host writes are refused while busy, so the ports never collide
    a_one_writer: assert property (@(posedge clk) disable iff (!arst_n)
        !(exec_we && host_we))
        else $error("Execution and host write in the same cycle");

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the ALU unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_alu_unit -o tb_alu_unit

# A failing check ends in $fatal, which gives a nonzero exit status
./obj_dir/tb_alu_unit

//--- sim.f
alu_pkg.sv
alu_core.sv
reg_file.sv
alu_exec.sv
alu_regs.sv
alu_unit_top.sv
tb_alu_unit.sv

//--- tb_alu_unit.sv
/*
 * Self-checking testbench for the 8-bit ALU unit
 * Drives the AXI4-Lite host port and checks against a reference ALU model
 */
`default_nettype none

module tb_alu_unit;
    import alu_pkg::*;

    localparam int num_regs   = 8;
    localparam int wait_limit = 64;
    // F bits that can hold a one
    localparam logic [7:0] flag_mask = 8'hd7;

    logic        clk;
    logic        arst_n;
    logic [7:0]  axi_awaddr;
    logic        axi_awvalid;
    logic        axi_awready;
    logic [31:0] axi_wdata;
    logic        axi_wvalid;
    logic        axi_wready;
    logic [1:0]  axi_bresp;
    logic        axi_bvalid;
    logic        axi_bready;
    logic [7:0]  axi_araddr;
    logic        axi_arvalid;
    logic        axi_arready;
    logic [31:0] axi_rdata;
    logic [1:0]  axi_rresp;
    logic        axi_rvalid;
    logic        axi_rready;

    // Expected contents of the unit
    logic [7:0]  regs_model [num_regs];
    logic [7:0]  f_model;
    int          seed;
    // Edge count and the edge of the last write handshake
    int          cycles;
    int          aw_cycle;

    alu_unit_top #(.num_regs(num_regs)) uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .axi_awaddr  (axi_awaddr),
        .axi_awvalid (axi_awvalid),
        .axi_awready (axi_awready),
        .axi_wdata   (axi_wdata),
        .axi_wvalid  (axi_wvalid),
        .axi_wready  (axi_wready),
        .axi_bresp   (axi_bresp),
        .axi_bvalid  (axi_bvalid),
        .axi_bready  (axi_bready),
        .axi_araddr  (axi_araddr),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_rdata   (axi_rdata),
        .axi_rresp   (axi_rresp),
        .axi_rvalid  (axi_rvalid),
        .axi_rready  (axi_rready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp)
            else stop_run($sformatf("Mismatch %s exp %h got %h", name, exp, got));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Host model
    // ~~~~~~~~~~~~~~~~~~~~
    // Tasks start and end a short delay after a rising edge
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input int hold, output logic [1:0] resp);
        int t;
        int k;
        axi_awaddr  = addr;
        axi_wdata   = data;
        axi_awvalid = 1'b1;
        axi_wvalid  = 1'b1;
        t = 0;
        while (!axi_awready) begin
            @(posedge clk);
            #1;
            t++;
            if (t > wait_limit) stop_run("Timeout: write address never accepted");
        end
        @(posedge clk);
        #1;
        aw_cycle    = cycles;
        axi_awvalid = 1'b0;
        axi_wvalid  = 1'b0;
        t = 0;
        while (!axi_bvalid) begin
            @(posedge clk);
            #1;
            t++;
            if (t > wait_limit) stop_run("Timeout: no write response");
        end
        resp = axi_bresp;
        // Stall the response channel
        for (k = 0; k < hold; k++) begin
            @(posedge clk);
            #1;
        end
        axi_bready = 1'b1;
        @(posedge clk);
        #1;
        axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        int t;
        int k;
        axi_araddr  = addr;
        axi_arvalid = 1'b1;
        t = 0;
        while (!axi_arready) begin
            @(posedge clk);
            #1;
            t++;
            if (t > wait_limit) stop_run("Timeout: read address never accepted");
        end
        @(posedge clk);
        #1;
        axi_arvalid = 1'b0;
        t = 0;
        while (!axi_rvalid) begin
            @(posedge clk);
            #1;
            t++;
            if (t > wait_limit) stop_run("Timeout: no read data");
        end
        data = axi_rdata;
        resp = axi_rresp;
        for (k = 0; k < hold; k++) begin
            @(posedge clk);
            #1;
        end
        axi_rready = 1'b1;
        @(posedge clk);
        #1;
        axi_rready = 1'b0;
    endtask

    task automatic write_reg(input int i, input logic [7:0] v);
        logic [1:0] resp;
        axi_write(8'(addr_reg_base + 4 * i), {24'h0, v}, 0, resp);
        check_value("axi_bresp", {30'h0, resp_okay}, {30'h0, resp});
        regs_model[i] = v;
    endtask

    task automatic check_reg(input int i);
        logic [31:0] rd;
        logic [1:0]  resp;
        axi_read(8'(addr_reg_base + 4 * i), 0, rd, resp);
        check_value("axi_rresp", {30'h0, resp_okay}, {30'h0, resp});
        check_value($sformatf("reg r%0d", i), {24'h0, regs_model[i]}, rd);
    endtask

    // Poll STATUS until busy is low
    task automatic wait_idle(output logic [31:0] st);
        int         t;
        logic [1:0] resp;
        t = 0;
        axi_read(addr_status, 0, st, resp);
        while (st[0]) begin
            t++;
            if (t > wait_limit) stop_run("Timeout: busy never fell");
            axi_read(addr_status, 0, st, resp);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference ALU
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic void alu_model(input alu_op_t op, input logic [7:0] a,
            input logic [7:0] b, input logic cin, output logic [7:0] res,
            output logic [7:0] f);
        int         c;
        int         full;
        int         nib;
        int         sgn;
        int         ones;
        int         k;
        logic [7:0] r;
        c = ((op == op_adc) || (op == op_sbc)) ? int'(cin) : 0;
        f = 8'h00;
        case (op)
            op_add, op_adc: begin
                full       = int'(a) + int'(b) + c;
                nib        = int'(a[3:0]) + int'(b[3:0]) + c;
                sgn        = int'($signed(a)) + int'($signed(b)) + c;
                r          = full[7:0];
                f[flag_c]  = (full > 255);
                f[flag_h]  = (nib > 15);
                f[flag_pv] = (sgn > 127) || (sgn < -128);
            end
            op_sub, op_sbc, op_cp: begin
                // Borrows show as negative totals
                full       = int'(a) - int'(b) - c;
                nib        = int'(a[3:0]) - int'(b[3:0]) - c;
                sgn        = int'($signed(a)) - int'($signed(b)) - c;
                r          = full[7:0];
                f[flag_c]  = (full < 0);
                f[flag_h]  = (nib < 0);
                f[flag_pv] = (sgn > 127) || (sgn < -128);
                f[flag_n]  = 1'b1;
            end
            default: begin
                r = (op == op_and) ? (a & b) : (op == op_xor) ? (a ^ b) : (a | b);
                ones = 0;
                for (k = 0; k < 8; k++) begin
                    ones = ones + int'(r[k]);
                end
                f[flag_pv] = ((ones % 2) == 0);
                f[flag_h]  = (op == op_and);
            end
        endcase
        f[flag_s] = r[7];
        f[flag_z] = (r == 8'h00);
        res = r;
    endfunction

    function automatic logic [31:0] encode_cmd(input alu_op_t op, input int ai, input int bi);
        logic [31:0] w;
        w = 32'h0;
        w[cmd_op_lsb +: 3] = op;
        w[cmd_a_lsb +: 3]  = 3'(ai);
        w[cmd_b_lsb +: 3]  = 3'(bi);
        return w;
    endfunction

    // Load operands and F, run one op, check F, destination and source
    task automatic run_op(input alu_op_t op, input int ai, input int bi,
                          input logic [7:0] va, input logic [7:0] vb, input logic [7:0] f_in);
        logic [7:0]  exp_res;
        logic [7:0]  exp_f;
        logic [31:0] st;
        logic [31:0] rd;
        logic [1:0]  resp;
        write_reg(ai, va);
        write_reg(bi, vb);
        axi_write(addr_flags, {24'h0, f_in}, 0, resp);
        check_value("axi_bresp", {30'h0, resp_okay}, {30'h0, resp});
        f_model = f_in & flag_mask;
        // FLAGS reads back with bits 3 and 5 cleared
        axi_read(addr_flags, 0, rd, resp);
        check_value("flags", {24'h0, f_model}, rd);
        alu_model(op, va, vb, f_model[flag_c], exp_res, exp_f);
        axi_write(addr_cmd, encode_cmd(op, ai, bi), 0, resp);
        check_value("axi_bresp", {30'h0, resp_okay}, {30'h0, resp});
        wait_idle(st);
        check_value("status flags", {24'h0, exp_f}, {24'h0, st[15:8]});
        f_model = exp_f;
        // CP leaves the destination alone
        if (op != op_cp) regs_model[ai] = exp_res;
        check_reg(ai);
        check_reg(bi);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Protocol checks
    // ~~~~~~~~~~~~~~~~~~~~
    a_rresp_okay: assert property (@(posedge clk) disable iff (!arst_n)
        axi_rvalid |-> axi_rresp == resp_okay)
        else stop_run($sformatf("Mismatch axi_rresp exp %h got %h", resp_okay, axi_rresp));
    a_rdata_held: assert property (@(posedge clk) disable iff (!arst_n)
        axi_rvalid && !axi_rready |=> axi_rvalid && $stable(axi_rdata))
        else stop_run("Read data changed or vanished under back-pressure");
    a_bresp_held: assert property (@(posedge clk) disable iff (!arst_n)
        axi_bvalid && !axi_bready |=> axi_bvalid && $stable(axi_bresp))
        else stop_run("Write response changed or vanished under back-pressure");
    a_ready_pair: assert property (@(posedge clk) disable iff (!arst_n)
        axi_wready == axi_awready)
        else stop_run($sformatf("Mismatch axi_wready exp %h got %h", axi_awready, axi_wready));
    a_no_ar_pending: assert property (@(posedge clk) disable iff (!arst_n)
        axi_rvalid |-> !axi_arready)
        else stop_run("Read address accepted while read data was pending");
    a_no_aw_pending: assert property (@(posedge clk) disable iff (!arst_n)
        axi_bvalid |-> !axi_awready)
        else stop_run("Write accepted while a write response was pending");

    initial begin
        logic [31:0] rd;
        logic [31:0] st;
        logic [1:0]  resp;
        logic [7:0]  va;
        logic [7:0]  vb;
        logic [7:0]  exp_res;
        logic [7:0]  exp_f;
        int          ai;
        int          bi;
        int          cmd_cycle;
        seed        = 57;
        arst_n      = 1'b0;
        axi_awaddr  = 8'h00;
        axi_awvalid = 1'b0;
        axi_wdata   = 32'h0;
        axi_wvalid  = 1'b0;
        axi_bready  = 1'b0;
        axi_araddr  = 8'h00;
        axi_arvalid = 1'b0;
        axi_rready  = 1'b0;
        f_model     = 8'h00;
        for (int i = 0; i < num_regs; i++) begin
            regs_model[i] = 8'h00;
        end
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Reset state and zero reads from unmapped addresses
        axi_read(addr_status, 0, rd, resp);
        check_value("status", 32'h0, rd);
        for (int i = 0; i < num_regs; i++) begin
            check_reg(i);
        end
        axi_read(8'h10, 0, rd, resp);
        check_value("unmapped rdata", 32'h0, rd);
        axi_read(8'h60, 0, rd, resp);
        check_value("unmapped rdata", 32'h0, rd);

        // Register window
        for (int i = 0; i < num_regs; i++) begin
            write_reg(i, 8'($random(seed)));
        end
        for (int i = 0; i < num_regs; i++) begin
            check_reg(i);
        end

        // Directed corners for overflow, borrow, zero and carry chains
        run_op(op_add, 0, 1, 8'h7f, 8'h01, 8'h00);
        run_op(op_adc, 6, 7, 8'hff, 8'h00, 8'h01);
        run_op(op_sub, 2, 3, 8'h00, 8'h01, 8'h00);
        run_op(op_sbc, 4, 5, 8'h80, 8'h00, 8'h01);
        run_op(op_and, 1, 2, 8'hf0, 8'h0f, 8'hff);
        run_op(op_cp, 3, 4, 8'h42, 8'h42, 8'h00);

        // Random operands over all eight ops
        for (int o = 0; o < 8; o++) begin
            for (int n = 0; n < 6; n++) begin
                ai = $random(seed) & 7;
                bi = (ai + 1 + ($random(seed) & 3)) % num_regs;
                run_op(alu_op_t'(o), ai, bi, 8'($random(seed)), 8'($random(seed)),
                    8'($random(seed)));
            end
            axi_read(addr_cmd, 0, rd, resp);
            check_value("cmd readback", encode_cmd(alu_op_t'(o), ai, bi), rd);
        end

        // Register write lands in the second busy cycle
        va = 8'($random(seed));
        vb = 8'($random(seed));
        write_reg(5, va);
        write_reg(6, vb);
        alu_model(op_add, va, vb, f_model[flag_c], exp_res, exp_f);
        axi_write(addr_cmd, encode_cmd(op_add, 5, 6), 0, resp);
        check_value("axi_bresp", {30'h0, resp_okay}, {30'h0, resp});
        cmd_cycle = aw_cycle;
        axi_write(8'(addr_reg_base + 20), 32'h0000_005a, 0, resp);
        wait_idle(st);
        check_value("status flags", {24'h0, exp_f}, {24'h0, st[15:8]});
        f_model = exp_f;
        // STATUS shows busy up to the third edge after the CMD handshake
        if ((aw_cycle - cmd_cycle) <= 3) begin
            check_value("axi_bresp", {30'h0, resp_slverr}, {30'h0, resp});
            regs_model[5] = exp_res;
        end else begin
            check_value("axi_bresp", {30'h0, resp_okay}, {30'h0, resp});
            regs_model[5] = 8'h5a;
        end
        check_reg(5);
        check_reg(6);

        // Back-pressure on both response channels
        vb = 8'($random(seed));
        axi_write(8'(addr_reg_base + 12), {24'h0, vb}, 4, resp);
        check_value("axi_bresp", {30'h0, resp_okay}, {30'h0, resp});
        regs_model[3] = vb;
        axi_read(8'(addr_reg_base + 12), 5, rd, resp);
        check_value("reg r3", {24'h0, vb}, rd);
        check_reg(4);
        axi_read(addr_status, 3, rd, resp);
        check_value("status", {16'h0, f_model, 8'h0}, rd);
        check_reg(3);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
